//--- common/axi_wr_pkg.sv
package axi_wr_pkg;

    ////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    // Slave-side ID carries the sequence number above the master ID
    localparam int mid_w = 2;
    localparam int seq_w = 4;
    localparam int sid_w = mid_w + seq_w;

    ////////////////////////////////////////
    // Address map
    ////////////////////////////////////////

    localparam int num_slaves = 6;

    typedef logic [2:0] slave_idx_t;

    // Catches every unmapped address for decode errors
    localparam slave_idx_t default_slave = 3'd5;

    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10
    } burst_e;

    ////////////////////////////////////////
    // Channel payloads
    ////////////////////////////////////////

    // Write address beat as the master sends it
    typedef struct packed {
        logic [mid_w-1:0]  id;
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        burst_e            burst;
    } aw_req_t;

    // Same beat after ID tagging, broadcast to all slaves
    typedef struct packed {
        logic [sid_w-1:0]  id;
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        burst_e            burst;
    } aw_fwd_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } w_beat_t;

    // Top three address bits pick the slave, 5 to 7 fall to the default slave
    function automatic slave_idx_t decode_slave(input logic [addr_w-1:0] addr);
        slave_idx_t region;
        region = addr[addr_w-1 -: 3];
        if (region < default_slave) begin
            return region;
        end
        return default_slave;
    endfunction

endpackage

//--- hw/route_fifo.sv
module route_fifo
    import axi_wr_pkg::*;
#(
    parameter int fifo_depth = 4
) (
    input  logic       clk,
    input  logic       rst_n,

    input  logic       push,
    input  slave_idx_t push_idx,
    input  logic       pop,

    output slave_idx_t head_idx,
    output logic       empty,
    output logic       full
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    slave_idx_t       mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_idx;
        end
    end

    ////////////////////////////////////////
    // Pointers and fill level
    ////////////////////////////////////////

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the level unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign head_idx = mem[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == cnt_w'(fifo_depth));

    // Tagger and router must respect the flags
    a_no_push_full : assert property (
        @(posedge clk) disable iff (!rst_n) push |-> !full
    ) else $error("route_fifo: push while full");

    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (!rst_n) pop |-> !empty
    ) else $error("route_fifo: pop while empty");

endmodule

//--- hw/aw_tagger.sv
module aw_tagger
    import axi_wr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  aw_req_t               m_aw,
    input  logic                  m_aw_valid,
    output logic                  m_aw_ready,

    output aw_fwd_t               s_aw,
    output logic [num_slaves-1:0] s_aw_valid,
    input  logic [num_slaves-1:0] s_aw_ready,

    // Route FIFO write side
    input  logic                  full,
    output logic                  push,
    output slave_idx_t            push_idx
);

    logic [seq_w-1:0] seq;
    slave_idx_t       target;
    logic             accept;

    ////////////////////////////////////////
    // Decode and steer
    ////////////////////////////////////////

    assign target = decode_slave(m_aw.addr);

    // Payload goes to every slave, only the target sees valid
    always_comb begin
        s_aw.id    = {seq, m_aw.id};
        s_aw.addr  = m_aw.addr;
        s_aw.len   = m_aw.len;
        s_aw.size  = m_aw.size;
        s_aw.burst = m_aw.burst;
    end

    always_comb begin
        s_aw_valid = '0;
        // Hold the address back while no route slot is free
        if (m_aw_valid && !full) begin
            s_aw_valid[target] = 1'b1;
        end
    end

    // Ready comes back only from the slave that was offered the beat
    assign m_aw_ready = |(s_aw_valid & s_aw_ready);
    assign accept     = m_aw_valid && m_aw_ready;

    assign push     = accept;
    assign push_idx = target;

    ////////////////////////////////////////
    // Sequence counter
    ////////////////////////////////////////

    // Counts accepted addresses, wraps at 16
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seq <= '0;
        end else if (accept) begin
            seq <= seq + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // An offered address stays on the same slave until that slave takes it
    a_aw_valid_held : assert property (
        @(posedge clk) disable iff (!rst_n)
        (|s_aw_valid && !m_aw_ready) |=> $stable(s_aw_valid)
    ) else $error("aw_tagger: AW valid dropped or moved before the handshake");

endmodule

//--- hw/w_router.sv
module w_router
    import axi_wr_pkg::*;
(
    // Master write data
    input  w_beat_t               m_w,
    input  logic                  m_w_valid,
    output logic                  m_w_ready,

    // Broadcast data, one handshake bit per slave
    output w_beat_t               s_w,
    output logic [num_slaves-1:0] s_w_valid,
    input  logic [num_slaves-1:0] s_w_ready,

    // Route FIFO read side
    input  slave_idx_t            head_idx,
    input  logic                  empty,
    output logic                  pop
);

    logic beat_done;

    ////////////////////////////////////////
    // Steering
    ////////////////////////////////////////

    // Beats pass unchanged, the route only picks who sees valid
    assign s_w = m_w;

    always_comb begin
        s_w_valid = '0;
        m_w_ready = 1'b0;
        // No route yet, so early data waits at the master
        if (!empty) begin
            s_w_valid[head_idx] = m_w_valid;
            m_w_ready           = s_w_ready[head_idx];
        end
    end

    ////////////////////////////////////////
    // Route release
    ////////////////////////////////////////

    assign beat_done = m_w_valid && m_w_ready;

    // Last beat of the burst frees the head route
    assign pop = beat_done && m_w.last;

endmodule

//--- hw/axi_wr_interconnect.sv
module axi_wr_interconnect
    import axi_wr_pkg::*;
#(
    parameter int fifo_depth = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // Master side
    input  aw_req_t               m_aw,
    input  logic                  m_aw_valid,
    output logic                  m_aw_ready,
    input  w_beat_t               m_w,
    input  logic                  m_w_valid,
    output logic                  m_w_ready,

    // Slave side, payloads broadcast and one handshake bit per slave
    output aw_fwd_t               s_aw,
    output logic [num_slaves-1:0] s_aw_valid,
    input  logic [num_slaves-1:0] s_aw_ready,
    output w_beat_t               s_w,
    output logic [num_slaves-1:0] s_w_valid,
    input  logic [num_slaves-1:0] s_w_ready
);

    ////////////////////////////////////////
    // Route queue between AW and W
    ////////////////////////////////////////

    logic       push;
    slave_idx_t push_idx;
    logic       pop;
    slave_idx_t head_idx;
    logic       empty;
    logic       full;

    // Address side
    aw_tagger i_aw_tagger (
        .clk        (clk),
        .rst_n      (rst_n),
        .m_aw       (m_aw),
        .m_aw_valid (m_aw_valid),
        .m_aw_ready (m_aw_ready),
        .s_aw       (s_aw),
        .s_aw_valid (s_aw_valid),
        .s_aw_ready (s_aw_ready),
        .full       (full),
        .push       (push),
        .push_idx   (push_idx)
    );

    route_fifo #(
        .fifo_depth (fifo_depth)
    ) i_route_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (push),
        .push_idx (push_idx),
        .pop      (pop),
        .head_idx (head_idx),
        .empty    (empty),
        .full     (full)
    );

    // Data side
    w_router i_w_router (
        .m_w       (m_w),
        .m_w_valid (m_w_valid),
        .m_w_ready (m_w_ready),
        .s_w       (s_w),
        .s_w_valid (s_w_valid),
        .s_w_ready (s_w_ready),
        .head_idx  (head_idx),
        .empty     (empty),
        .pop       (pop)
    );

endmodule

//--- testbench/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held for the first 10 cycles
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- testbench/tb_axi_wr_interconnect.sv
module tb_axi_wr_interconnect
    import axi_wr_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int fifo_depth     = 4;
    localparam int n_rows         = 18;
    localparam int timeout_cycles = 2000;

    // Full 4-byte beats on the 32-bit bus
    localparam logic [2:0] beat_size = 3'd2;

    typedef struct packed {
        logic [mid_w-1:0]  id;
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
        burst_e            burst;
        logic [data_w-1:0] seed;
        slave_idx_t        exp_slave;
    } row_t;

    // id, address, len, burst, data seed, expected slave from the top 3 address bits
    localparam row_t rows [n_rows] = '{
        '{2'd0, 32'h0000_0040, 8'd3, burst_incr,  32'h1000_0000, 3'd0},
        '{2'd1, 32'h2000_0100, 8'd0, burst_incr,  32'h2000_0000, 3'd1},
        '{2'd2, 32'h4000_0200, 8'd7, burst_wrap,  32'h3000_0000, 3'd2},
        '{2'd3, 32'h6000_0010, 8'd1, burst_fixed, 32'h4000_0000, 3'd3},
        '{2'd0, 32'h8000_0400, 8'd2, burst_incr,  32'h5000_0000, 3'd4},
        '{2'd1, 32'hA000_0000, 8'd0, burst_incr,  32'h6000_0000, 3'd5},
        '{2'd2, 32'hC000_0800, 8'd1, burst_incr,  32'h7000_0000, 3'd5},
        '{2'd3, 32'hE000_0020, 8'd4, burst_incr,  32'h8000_0000, 3'd5},
        '{2'd0, 32'h1FFF_FFFC, 8'd1, burst_incr,  32'h9000_0000, 3'd0},
        '{2'd1, 32'h3FFF_0000, 8'd2, burst_incr,  32'hA000_0000, 3'd1},
        '{2'd2, 32'h5000_0000, 8'd0, burst_fixed, 32'hB000_0000, 3'd2},
        '{2'd3, 32'h7000_1000, 8'd5, burst_incr,  32'hC000_0000, 3'd3},
        '{2'd0, 32'h9000_0000, 8'd3, burst_wrap,  32'hD000_0000, 3'd4},
        '{2'd1, 32'hBFFF_FFF0, 8'd1, burst_incr,  32'hE000_0000, 3'd5},
        '{2'd2, 32'h0800_0000, 8'd2, burst_incr,  32'hF000_0000, 3'd0},
        '{2'd3, 32'hDEAD_BEE0, 8'd0, burst_incr,  32'h0100_0000, 3'd5},
        '{2'd0, 32'hF000_0000, 8'd1, burst_incr,  32'h0200_0000, 3'd5},
        '{2'd1, 32'h6400_0040, 8'd2, burst_incr,  32'h0300_0000, 3'd3}
    };

    logic                  clk;
    logic                  rst_n;
    aw_req_t               m_aw;
    logic                  m_aw_valid;
    logic                  m_aw_ready;
    w_beat_t               m_w;
    logic                  m_w_valid;
    logic                  m_w_ready;
    aw_fwd_t               s_aw;
    logic [num_slaves-1:0] s_aw_valid;
    logic [num_slaves-1:0] s_aw_ready;
    w_beat_t               s_w;
    logic [num_slaves-1:0] s_w_valid;
    logic [num_slaves-1:0] s_w_ready;

    // Data slaves stay not ready until the route FIFO has filled
    logic hold_w;

    int aw_count   = 0;
    int w_row      = 0;
    int w_beat     = 0;
    int beat_total = 0;
    int w_bursts [num_slaves] = '{default: 0};
    int errors     = 0;
    int timeouts   = 0;

    tb_clock i_tb_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    axi_wr_interconnect #(
        .fifo_depth (fifo_depth)
    ) i_axi_wr_interconnect (
        .clk        (clk),
        .rst_n      (rst_n),
        .m_aw       (m_aw),
        .m_aw_valid (m_aw_valid),
        .m_aw_ready (m_aw_ready),
        .m_w        (m_w),
        .m_w_valid  (m_w_valid),
        .m_w_ready  (m_w_ready),
        .s_aw       (s_aw),
        .s_aw_valid (s_aw_valid),
        .s_aw_ready (s_aw_ready),
        .s_w        (s_w),
        .s_w_valid  (s_w_valid),
        .s_w_ready  (s_w_ready)
    );

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] next_rand(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task check_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("error %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task report_timeout(input string what);
        timeouts++;
        $display("timeout while waiting for %s", what);
    endtask

    ////////////////////////////////////////
    // Slave models
    ////////////////////////////////////////

    initial begin
        logic [31:0] lcg_state;
        lcg_state  = 32'h108ee486;
        s_aw_ready = '0;
        s_w_ready  = '0;
        forever begin
            @(posedge clk);
            lcg_state = next_rand(lcg_state);
            s_aw_ready <= lcg_state[21:16];
            s_w_ready  <= hold_w ? '0 : lcg_state[29:24];
        end
    end

    // Addresses must arrive in table order
    task check_address(input int s);
        row_t row;
        if (aw_count >= n_rows) begin
            errors++;
            $display("slave %0d received an address beyond the end of the table", s);
            return;
        end
        row = rows[aw_count];
        check_value("aw_slave", 32'(row.exp_slave), 32'(s));
        check_value("aw_id", 32'({aw_count[3:0], row.id}), 32'(s_aw.id));
        check_value("aw_addr", row.addr, s_aw.addr);
        check_value("aw_len", 32'(row.len), 32'(s_aw.len));
        check_value("aw_size", 32'(beat_size), 32'(s_aw.size));
        check_value("aw_burst", 32'(row.burst), 32'(s_aw.burst));
        aw_count <= aw_count + 1;
    endtask

    task check_beat(input int s);
        row_t row;
        logic last_beat;
        if (w_row >= n_rows) begin
            errors++;
            $display("slave %0d received a data beat beyond the end of the table", s);
            return;
        end
        row       = rows[w_row];
        last_beat = (w_beat == int'(row.len));
        check_value("w_slave", 32'(row.exp_slave), 32'(s));
        check_value("w_after_aw", 32'(1), 32'(w_row < aw_count));
        check_value("w_data", row.seed + w_beat, s_w.data);
        check_value("w_strb", 32'(4'hf), 32'(s_w.strb));
        check_value("w_last", 32'(last_beat), 32'(s_w.last));
        beat_total <= beat_total + 1;
        if (last_beat) begin
            w_row       <= w_row + 1;
            w_beat      <= 0;
            w_bursts[s] <= w_bursts[s] + 1;
        end else begin
            w_beat <= w_beat + 1;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            for (int s = 0; s < num_slaves; s++) begin
                if (s_aw_valid[s] && s_aw_ready[s]) begin
                    check_address(s);
                end
                if (s_w_valid[s] && s_w_ready[s]) begin
                    check_beat(s);
                end
            end
        end
    end

    ////////////////////////////////////////
    // Master processes
    ////////////////////////////////////////

    task automatic send_addresses();
        int wait_cycles;
        for (int r = 0; r < n_rows; r++) begin
            m_aw <= '{id: rows[r].id, addr: rows[r].addr, len: rows[r].len,
                      size: beat_size, burst: rows[r].burst};
            m_aw_valid  <= 1'b1;
            wait_cycles = 0;
            do begin
                @(posedge clk);
                wait_cycles++;
            end while (!m_aw_ready && wait_cycles < timeout_cycles);
            if (!m_aw_ready) begin
                report_timeout("an address handshake");
                break;
            end
        end
        m_aw_valid <= 1'b0;
    endtask

    // Starts with the addresses, so the first beats wait for a route
    task automatic send_data();
        int wait_cycles;
        for (int r = 0; r < n_rows; r++) begin
            for (int b = 0; b <= int'(rows[r].len); b++) begin
                m_w <= '{data: rows[r].seed + b, strb: '1, last: (b == int'(rows[r].len))};
                m_w_valid   <= 1'b1;
                wait_cycles = 0;
                do begin
                    @(posedge clk);
                    wait_cycles++;
                end while (!m_w_ready && wait_cycles < timeout_cycles);
                if (!m_w_ready) begin
                    report_timeout("a data handshake");
                    m_w_valid <= 1'b0;
                    return;
                end
            end
        end
        m_w_valid <= 1'b0;
    endtask

    task automatic stall_until_full();
        int wait_cycles;
        wait_cycles = 0;
        while (aw_count < fifo_depth && wait_cycles < timeout_cycles) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (aw_count < fifo_depth) begin
            report_timeout("four pending routes");
        end
        // Nothing drains, so the next address must stall
        repeat (8) begin
            @(posedge clk);
            check_value("aw_pending", 32'(1), 32'(m_aw_valid));
            check_value("aw_ready_full", 32'(0), 32'(m_aw_ready));
        end
        hold_w <= 1'b0;
    endtask

    initial begin
        int wait_cycles;
        int expected_beats;
        int exp_bursts [num_slaves];
        m_aw       = '0;
        m_aw_valid = 1'b0;
        m_w        = '0;
        m_w_valid  = 1'b0;
        hold_w     = 1'b0;
        wait_cycles = 0;
        while (rst_n !== 1'b1 && wait_cycles < 100) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (rst_n !== 1'b1) begin
            report_timeout("reset release");
        end
        // Idle bus while the slaves toggle ready at random
        repeat (4) begin
            @(posedge clk);
            check_value("idle_s_aw_valid", 32'(0), 32'(s_aw_valid));
            check_value("idle_s_w_valid", 32'(0), 32'(s_w_valid));
            check_value("idle_m_aw_ready", 32'(0), 32'(m_aw_ready));
            check_value("idle_m_w_ready", 32'(0), 32'(m_w_ready));
        end
        // Data slaves go quiet before the first route can reach the head
        hold_w <= 1'b1;

        fork
            send_addresses();
            send_data();
            stall_until_full();
        join
        @(posedge clk);

        // Totals from the table
        expected_beats = 0;
        for (int s = 0; s < num_slaves; s++) begin
            exp_bursts[s] = 0;
        end
        for (int r = 0; r < n_rows; r++) begin
            expected_beats += int'(rows[r].len) + 1;
            exp_bursts[rows[r].exp_slave]++;
        end
        check_value("aw_total", 32'(n_rows), 32'(aw_count));
        check_value("burst_total", 32'(n_rows), 32'(w_row));
        check_value("beat_total", 32'(expected_beats), 32'(beat_total));
        for (int s = 0; s < num_slaves; s++) begin
            check_value($sformatf("bursts_slave_%0d", s), 32'(exp_bursts[s]), 32'(w_bursts[s]));
        end

        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- all.f
common/axi_wr_pkg.sv
hw/route_fifo.sv
hw/aw_tagger.sv
hw/w_router.sv
hw/axi_wr_interconnect.sv
testbench/tb_clock.sv
testbench/tb_axi_wr_interconnect.sv

//--- run.sh
#!/bin/sh
# Build and run the AXI write interconnect testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_axi_wr_interconnect \
    -f all.f

output=$(./obj_dir/Vtb_axi_wr_interconnect)
echo "$output"

if echo "$output" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1
